// ==== img_controller.f ====
+incdir+tests
logic/img_geom_pkg.sv
logic/img_ctrl_pkg.sv
logic/image_bank.sv
logic/pixel_stats.sv
logic/frame_writer.sv
logic/bank_reader.sv
logic/img_controller.sv
tests/tb_img_controller.sv

// ==== tests/img_model.svh ====
`ifndef IMG_MODEL_SVH
`define IMG_MODEL_SVH

// ========================================================================
// Reference model of the image record
// ========================================================================

// Every fourth pixel of every fourth line is examined
localparam int SAMPLE_STRIDE = 4;

// Expected bank contents and record lengths
word_t     exp_mem [BANK_COUNT][BANK_DEPTH];
int        exp_len [BANK_COUNT];

// Expected status of the most recent capture
int        exp_words;
int        exp_highlights;
int        exp_shadows;

bank_sel_t rec_bank;
int        run_sum1;
int        run_sum2;
int        pixels_kept;

// Fletcher-32 step, both sums modulo 65535
function automatic void fletcher_step(input word_t w);
    run_sum1 = (run_sum1 + int'(w)) % 65535;
    run_sum2 = (run_sum2 + run_sum1) % 65535;
endfunction

function automatic void start_record(input bank_sel_t bank, input header_t header);
    word_t w;
    rec_bank       = bank;
    run_sum1       = 0;
    run_sum2       = 0;
    pixels_kept    = 0;
    exp_highlights = 0;
    exp_shadows    = 0;
    // Header word 0 is the most significant
    for (int i = 0; i < HEADER_WORDS; i++) begin
        w = header[HEADER_BITS-1 - i*WORD_BITS -: WORD_BITS];
        exp_mem[bank][i] = w;
        fletcher_step(w);
    end
    exp_words = HEADER_WORDS;
endfunction

function automatic void record_pixel(input int line, input int col, input pixel_t pix);
    logic [STAT_TAG_BITS-1:0] tag;
    tag = pix[PIXEL_BITS-1 -: STAT_TAG_BITS];
    // Past capacity a pixel is neither stored nor counted
    if (pixels_kept < PIXEL_CAPACITY) begin
        exp_mem[rec_bank][exp_words] = word_t'(pix);
        fletcher_step(word_t'(pix));
        exp_words++;
        pixels_kept++;
        if (line % SAMPLE_STRIDE == 0 && col % SAMPLE_STRIDE == 0) begin
            if (tag == '1) begin
                exp_highlights++;
            end else if (tag == '0) begin
                exp_shadows++;
            end
        end
    end
endfunction

// Checksum words, sum2 first
function automatic void close_record();
    exp_mem[rec_bank][exp_words]     = word_t'(run_sum2);
    exp_mem[rec_bank][exp_words + 1] = word_t'(run_sum1);
    exp_words += CHECKSUM_WORDS;
    exp_len[rec_bank] = exp_words;
endfunction

`endif

// ==== tests/tb_img_controller.sv ====
`timescale 1ns/1ps

module tb_img_controller;
    import img_geom_pkg::*;
    import img_ctrl_pkg::*;

    localparam int FRAMES           = 3;
    // Largest frame driven including porch and blanking
    localparam int FRAME_CYCLES_MAX = 12 * (24 + 4) + 16;
    localparam int WATCHDOG_CYCLES  = FRAMES * FRAME_CYCLES_MAX * 4 + 8 * BANK_DEPTH * 4;
    localparam int DONE_TIMEOUT     = 64;
    localparam int BEAT_TIMEOUT     = 64;

    logic            clk;
    logic            readout_rst;
    logic            cmd_capture;
    logic            cmd_readout;
    bank_sel_t       cmd_bank;
    header_t         cmd_header;
    camera_in_t      camera;
    logic            readout_ready;
    logic            readout_valid;
    readout_beat_t   readout_beat;
    logic            busy;
    logic            capture_done;
    capture_status_t capture_status;

    int seed;
    int checks;
    int errors;

    `include "img_model.svh"

    img_controller i_dut (
        .clk(clk),
        .readout_rst(readout_rst),
        .cmd_capture(cmd_capture),
        .cmd_readout(cmd_readout),
        .cmd_bank(cmd_bank),
        .cmd_header(cmd_header),
        .camera(camera),
        .readout_ready(readout_ready),
        .readout_valid(readout_valid),
        .readout_beat(readout_beat),
        .busy(busy),
        .capture_done(capture_done),
        .capture_status(capture_status)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    // ========================================================================
    // Checking helpers
    // ========================================================================

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
            errors++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_status();
        compare_value("capture_status.word_count", capture_status.word_count, exp_words);
        compare_value("capture_status.highlights", capture_status.highlights, exp_highlights);
        compare_value("capture_status.shadows", capture_status.shadows, exp_shadows);
    endtask

    // ========================================================================
    // Camera stimulus
    // ========================================================================

    // Biased toward the highlight and shadow ranges
    function automatic pixel_t random_pixel();
        int r;
        r = $random(seed);
        case (r[1:0])
            2'd0:    return {{STAT_TAG_BITS{1'b1}}, r[8:4]};
            2'd1:    return {{STAT_TAG_BITS{1'b0}}, r[8:4]};
            default: return r[27:16];
        endcase
    endfunction

    task automatic drive_frame(input int lines, input int len);
        pixel_t pix;
        int     gap;
        @(negedge clk);
        camera = '{frame_valid: 1'b1, line_valid: 1'b0, pixel: '0};
        repeat (2) @(negedge clk);
        for (int l = 0; l < lines; l++) begin
            for (int c = 0; c < len; c++) begin
                pix    = random_pixel();
                camera = '{1'b1, 1'b1, pix};
                record_pixel(l, c, pix);
                @(negedge clk);
            end
            // Horizontal blanking
            gap = 1 + ($random(seed) & 3);
            camera.line_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        camera.frame_valid = 1'b0;
    endtask

    task automatic capture_frame(input bank_sel_t bank, input int lines, input int len,
                                 input bit poke);
        header_t header;
        int      waited;
        header = {$random(seed), $random(seed)};
        @(negedge clk);
        cmd_capture = 1'b1;
        cmd_bank    = bank;
        cmd_header  = header;
        start_record(bank, header);
        @(negedge clk);
        cmd_capture = 1'b0;
        compare_value("busy", busy, 1'b1);
        repeat (7) @(negedge clk);
        if (poke) begin
            // Readout request bounces while the writer waits for the frame
            cmd_readout = 1'b1;
            cmd_bank    = ~bank;
            @(negedge clk);
            cmd_readout = 1'b0;
        end
        drive_frame(lines, len);
        waited = 0;
        while (!capture_done && waited < DONE_TIMEOUT) begin
            expect_true(!readout_valid, "readout started during a capture");
            @(negedge clk);
            waited++;
        end
        expect_true(capture_done, "capture_done never pulsed after the frame");
        close_record();
        check_status();
    endtask

    // ========================================================================
    // Readout with random back-pressure
    // ========================================================================

    task automatic read_bank(input bank_sel_t bank, input bit poke);
        readout_beat_t held_beat;
        bit            held;
        bit            take;
        int            idx;
        int            n;
        int            waited;
        n = exp_len[bank];
        @(negedge clk);
        cmd_readout = 1'b1;
        cmd_bank    = bank;
        @(negedge clk);
        cmd_readout = 1'b0;
        compare_value("readout_valid", readout_valid, 1'b0);
        compare_value("busy", busy, n != 0);
        @(negedge clk);
        compare_value("readout_valid", readout_valid, n != 0);
        if (poke) begin
            cmd_header = ~cmd_header;
        end
        idx    = 0;
        held   = 1'b0;
        waited = 0;
        while (idx < n && waited < BEAT_TIMEOUT * n) begin
            cmd_capture = poke && waited == 5;
            if (readout_valid) begin
                if (held) begin
                    compare_value("readout_beat", readout_beat, held_beat);
                end
                take          = ($random(seed) & 3) != 0;
                readout_ready = take;
                held          = !take;
                held_beat     = readout_beat;
                if (take) begin
                    compare_value("readout_beat.data", readout_beat.data, exp_mem[bank][idx]);
                    compare_value("readout_beat.last", readout_beat.last, idx == n - 1);
                    idx++;
                end
            end else begin
                expect_true(!held, "readout_valid fell without a transfer");
                held          = 1'b0;
                readout_ready = $random(seed) & 1;
            end
            @(negedge clk);
            waited++;
        end
        readout_ready = 1'b0;
        cmd_capture   = 1'b0;
        expect_true(idx == n, "readout timed out before the last beat");
        compare_value("busy", busy, 1'b0);
        repeat (4) begin
            expect_true(!readout_valid, "extra beat after the last one");
            @(negedge clk);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        seed          = 32'h3acd;
        checks        = 0;
        errors        = 0;
        readout_rst   = 1'b0;
        cmd_capture   = 1'b0;
        cmd_readout   = 1'b0;
        cmd_bank      = '0;
        cmd_header    = '0;
        camera        = '0;
        readout_ready = 1'b0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            exp_len[b] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        readout_rst = 1'b1;
        @(negedge clk);
        compare_value("busy", busy, 1'b0);
        compare_value("readout_valid", readout_valid, 1'b0);
        compare_value("capture_done", capture_done, 1'b0);

        // Empty bank gives no beats
        read_bank(1, 1'b0);

        capture_frame(0, 2 + ($random(seed) & 7), 4 + ($random(seed) & 15), 1'b0);
        read_bank(0, 1'b0);

        // Second bank then both read back in reverse order
        capture_frame(1, 2 + ($random(seed) & 7), 4 + ($random(seed) & 15), 1'b1);
        read_bank(1, 1'b1);
        read_bank(0, 1'b0);
        check_status();

        // Oversized frame fills the bank exactly
        capture_frame(0, 12, 24, 1'b0);
        compare_value("capture_status.word_count", capture_status.word_count, BANK_DEPTH);
        read_bank(0, 1'b0);
        read_bank(1, 1'b0);
        check_status();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== logic/img_controller.sv ====
`timescale 1ns/1ps

module img_controller (
    input  logic                          clk,
    input  logic                          readout_rst,
    input  logic                          cmd_capture,
    input  logic                          cmd_readout,
    input  img_geom_pkg::bank_sel_t       cmd_bank,
    input  img_geom_pkg::header_t         cmd_header,
    input  img_ctrl_pkg::camera_in_t      camera,
    input  logic                          readout_ready,
    output logic                          readout_valid,
    output img_ctrl_pkg::readout_beat_t   readout_beat,
    output logic                          busy,
    output logic                          capture_done,
    output img_ctrl_pkg::capture_status_t capture_status
);
    import img_geom_pkg::*;
    import img_ctrl_pkg::*;

    logic         writer_busy;
    logic         reader_busy;
    logic         capture_go;
    logic         readout_go;
    bank_write_t  bank_wr;
    bank_commit_t bank_commit;
    logic         pixel_window;
    word_count_t  word_count;
    stat_count_t  highlights;
    stat_count_t  shadows;
    bank_addr_t   rd_addr;
    word_t        rd_words [BANK_COUNT];
    word_count_t  lengths [BANK_COUNT];

    // ========================================================================
    // Command acceptance
    // ========================================================================

    // Both engines must be idle, capture wins a tie
    assign busy       = writer_busy || reader_busy;
    assign capture_go = cmd_capture && !busy;
    assign readout_go = cmd_readout && !busy && !cmd_capture;

    assign capture_status = '{word_count: word_count, highlights: highlights, shadows: shadows};

    // ========================================================================
    // Engines and banks
    // ========================================================================

    frame_writer i_frame_writer (
        .clk(clk), .readout_rst(readout_rst), .start(capture_go), .bank(cmd_bank),
        .header(cmd_header), .camera(camera), .wr(bank_wr), .commit(bank_commit),
        .pixel_window(pixel_window), .word_count(word_count), .busy(writer_busy),
        .done(capture_done)
    );

    pixel_stats i_pixel_stats (
        .clk(clk), .readout_rst(readout_rst), .clear(capture_go), .camera(camera),
        .pixel_window(pixel_window), .highlights(highlights), .shadows(shadows)
    );

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        image_bank i_image_bank (
            .clk(clk), .readout_rst(readout_rst), .bank_id(bank_sel_t'(b)), .wr(bank_wr),
            .commit(bank_commit), .rd_addr(rd_addr), .rd_word(rd_words[b]), .length(lengths[b])
        );
    end

    bank_reader i_bank_reader (
        .clk(clk), .readout_rst(readout_rst), .start(readout_go), .bank(cmd_bank),
        .rd_addr(rd_addr), .rd_words(rd_words), .lengths(lengths),
        .readout_ready(readout_ready), .readout_valid(readout_valid),
        .readout_beat(readout_beat), .busy(reader_busy)
    );

endmodule

// ==== logic/bank_reader.sv ====
`timescale 1ns/1ps

module bank_reader (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic                        start,
    input  img_geom_pkg::bank_sel_t     bank,
    output img_geom_pkg::bank_addr_t    rd_addr,
    input  img_geom_pkg::word_t         rd_words [img_geom_pkg::BANK_COUNT],
    input  img_geom_pkg::word_count_t   lengths [img_geom_pkg::BANK_COUNT],
    input  logic                        readout_ready,
    output logic                        readout_valid,
    output img_ctrl_pkg::readout_beat_t readout_beat,
    output logic                        busy
);
    import img_geom_pkg::*;
    import img_ctrl_pkg::*;

    reader_state_e state;
    bank_sel_t     bank_q;
    word_count_t   length_q;
    bank_addr_t    addr_q;
    logic          fetch_done;
    logic          load;
    logic          last_word;

    // ========================================================================
    // Address sequencing
    // ========================================================================

    // The selected bank always shows mem[addr_q] while streaming
    assign load      = state != RD_IDLE && !fetch_done && (!readout_valid || readout_ready);
    assign last_word = word_count_t'(addr_q) == length_q - word_count_t'(1);
    // Look one word ahead only when the holding register takes the current one
    assign rd_addr   = load ? addr_q + 1'b1 : addr_q;
    assign busy      = state != RD_IDLE;

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state         <= RD_IDLE;
            bank_q        <= '0;
            length_q      <= '0;
            addr_q        <= '0;
            fetch_done    <= 1'b0;
            readout_valid <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    // Empty bank gives no beats
                    if (start && lengths[bank] != '0) begin
                        bank_q     <= bank;
                        length_q   <= lengths[bank];
                        fetch_done <= 1'b0;
                        state      <= RD_FETCH;
                    end
                end
                default: begin
                    if (readout_valid && readout_ready) begin
                        readout_valid <= 1'b0;
                    end
                    if (load) begin
                        readout_valid <= 1'b1;
                        addr_q        <= addr_q + 1'b1;
                        fetch_done    <= last_word;
                        state         <= RD_STREAM;
                    end
                    if (readout_valid && readout_ready && readout_beat.last) begin
                        addr_q <= '0;
                        state  <= RD_IDLE;
                    end
                end
            endcase
        end
    end

    // ========================================================================
    // Output holding register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (load) begin
            readout_beat.data <= rd_words[bank_q];
            readout_beat.last <= last_word;
        end
    end

endmodule

// ==== logic/frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer (
    input  logic                       clk,
    input  logic                       readout_rst,
    input  logic                       start,
    input  img_geom_pkg::bank_sel_t    bank,
    input  img_geom_pkg::header_t      header,
    input  img_ctrl_pkg::camera_in_t   camera,
    output img_ctrl_pkg::bank_write_t  wr,
    output img_ctrl_pkg::bank_commit_t commit,
    output logic                       pixel_window,
    output img_geom_pkg::word_count_t  word_count,
    output logic                       busy,
    output logic                       done
);
    import img_geom_pkg::*;
    import img_ctrl_pkg::*;

    writer_state_e                   state;
    bank_sel_t                       bank_q;
    header_t                         header_sr;
    logic [$clog2(HEADER_WORDS)-1:0] header_left;
    word_count_t                     wr_count;
    bank_addr_t                      next_addr;
    word_t                           sum1;
    word_t                           sum2;
    word_t                           sum1_next;
    word_t                           sum2_next;
    logic                            data_word;
    logic                            take_pixel;

    // One's complement style add, modulo 65535
    function automatic word_t fletcher_add(input word_t acc, input word_t val);
        logic [WORD_BITS:0] total;
        total = {1'b0, acc} + {1'b0, val};
        if (total >= {1'b0, {WORD_BITS{1'b1}}}) begin
            total = total - {1'b0, {WORD_BITS{1'b1}}};
        end
        return total[WORD_BITS-1:0];
    endfunction

    // ========================================================================
    // Fletcher-32 over the words on the write bus
    // ========================================================================

    // Checksum words stay out of the sums
    assign data_word = wr.strobe && state != WR_CHECK_HI && state != WR_CHECK_LO;
    assign sum1_next = data_word ? fletcher_add(sum1, wr.word) : sum1;
    assign sum2_next = data_word ? fletcher_add(sum2, sum1_next) : sum2;

    // Window closes once the pixel slots are used up
    assign pixel_window = (state == WR_WAIT_FRAME_HIGH || state == WR_PIXELS) &&
                          camera.frame_valid &&
                          wr_count < word_count_t'(HEADER_WORDS + PIXEL_CAPACITY);
    assign take_pixel   = pixel_window && camera.line_valid;
    assign next_addr    = bank_addr_t'(wr_count);
    assign word_count   = wr_count;
    assign busy         = state != WR_IDLE;

    always_ff @(posedge clk) begin
        if (state == WR_IDLE && start) begin
            header_sr <= header << WORD_BITS;
            sum1      <= '0;
            sum2      <= '0;
        end else begin
            if (state == WR_HEADER) begin
                header_sr <= header_sr << WORD_BITS;
            end
            sum1 <= sum1_next;
            sum2 <= sum2_next;
        end
    end

    // ========================================================================
    // Capture sequencing
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state       <= WR_IDLE;
            bank_q      <= '0;
            header_left <= '0;
            wr_count    <= '0;
            wr          <= '0;
            commit      <= '0;
            done        <= 1'b0;
        end else begin
            wr.strobe     <= 1'b0;
            commit.strobe <= 1'b0;
            done          <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (start) begin
                        // First header word goes out right away
                        bank_q      <= bank;
                        wr          <= '{1'b1, bank, '0, header[HEADER_BITS-1 -: WORD_BITS]};
                        wr_count    <= word_count_t'(1);
                        header_left <= $bits(header_left)'(HEADER_WORDS - 1);
                        state       <= WR_HEADER;
                    end
                end
                WR_HEADER: begin
                    if (header_left != '0) begin
                        wr          <= '{1'b1, bank_q, next_addr, header_sr[HEADER_BITS-1 -: WORD_BITS]};
                        wr_count    <= wr_count + word_count_t'(1);
                        header_left <= header_left - 1'b1;
                    end else begin
                        state <= WR_WAIT_FRAME_LOW;
                    end
                end
                WR_WAIT_FRAME_LOW: begin
                    if (!camera.frame_valid) begin
                        state <= WR_WAIT_FRAME_HIGH;
                    end
                end
                WR_WAIT_FRAME_HIGH: begin
                    if (camera.frame_valid) begin
                        state <= WR_PIXELS;
                    end
                end
                WR_PIXELS: begin
                    // Frame end, sum2 must include the last pixel still on the bus
                    if (!camera.frame_valid) begin
                        wr       <= '{1'b1, bank_q, next_addr, sum2_next};
                        wr_count <= wr_count + word_count_t'(1);
                        state    <= WR_CHECK_HI;
                    end
                end
                WR_CHECK_HI: begin
                    wr       <= '{1'b1, bank_q, next_addr, sum1};
                    commit   <= '{1'b1, bank_q, wr_count + word_count_t'(1)};
                    wr_count <= wr_count + word_count_t'(1);
                    state    <= WR_CHECK_LO;
                end
                default: begin
                    done  <= 1'b1;
                    state <= WR_IDLE;
                end
            endcase
            if (take_pixel) begin
                wr       <= '{1'b1, bank_q, next_addr, word_t'(camera.pixel)};
                wr_count <= wr_count + word_count_t'(1);
            end
        end
    end

endmodule

// ==== logic/pixel_stats.sv ====
`timescale 1ns/1ps

module pixel_stats (
    input  logic                      clk,
    input  logic                      readout_rst,
    input  logic                      clear,
    input  img_ctrl_pkg::camera_in_t  camera,
    input  logic                      pixel_window,
    output img_geom_pkg::stat_count_t highlights,
    output img_geom_pkg::stat_count_t shadows
);
    import img_geom_pkg::*;

    logic [STAT_STRIDE_BITS-1:0] col_pos;
    logic [STAT_STRIDE_BITS-1:0] line_pos;
    logic                        line_valid_q;
    logic                        sample;
    logic [STAT_TAG_BITS-1:0]    tag;

    // Every fourth pixel of every fourth line
    assign sample = pixel_window && camera.line_valid && col_pos == '0 && line_pos == '0;
    assign tag    = camera.pixel[PIXEL_BITS-1 -: STAT_TAG_BITS];

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            col_pos      <= '0;
            line_pos     <= '0;
            line_valid_q <= 1'b0;
            highlights   <= '0;
            shadows      <= '0;
        end else begin
            line_valid_q <= camera.line_valid;
            col_pos      <= camera.line_valid ? col_pos + 1'b1 : '0;
            // Line position steps on the falling edge of line valid
            if (!camera.frame_valid) begin
                line_pos <= '0;
            end else if (line_valid_q && !camera.line_valid) begin
                line_pos <= line_pos + 1'b1;
            end
            if (clear) begin
                highlights <= '0;
                shadows    <= '0;
            end else if (sample) begin
                if (&tag) begin
                    highlights <= highlights + 1'b1;
                end else if (~|tag) begin
                    shadows <= shadows + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/image_bank.sv ====
`timescale 1ns/1ps

module image_bank (
    input  logic                       clk,
    input  logic                       readout_rst,
    input  img_geom_pkg::bank_sel_t    bank_id,
    input  img_ctrl_pkg::bank_write_t  wr,
    input  img_ctrl_pkg::bank_commit_t commit,
    input  img_geom_pkg::bank_addr_t   rd_addr,
    output img_geom_pkg::word_t        rd_word,
    output img_geom_pkg::word_count_t  length
);
    import img_geom_pkg::*;

    word_t mem [BANK_DEPTH];

    // ========================================================================
    // Word storage
    // ========================================================================

    // Writes meant for the other bank are ignored
    always_ff @(posedge clk) begin
        if (wr.strobe && wr.bank == bank_id) begin
            mem[wr.addr] <= wr.word;
        end
        rd_word <= mem[rd_addr];
    end

    // Record length, 0 until a capture commits here
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            length <= '0;
        end else if (commit.strobe && commit.bank == bank_id) begin
            length <= commit.length;
        end
    end

endmodule

// ==== logic/img_ctrl_pkg.sv ====
package img_ctrl_pkg;

    // Camera pins as sampled in the clk domain
    typedef struct packed {
        logic                 frame_valid;
        logic                 line_valid;
        img_geom_pkg::pixel_t pixel;
    } camera_in_t;

    // Write port shared by all banks
    typedef struct packed {
        logic                     strobe;
        img_geom_pkg::bank_sel_t  bank;
        img_geom_pkg::bank_addr_t addr;
        img_geom_pkg::word_t      word;
    } bank_write_t;

    // End of record, carries the final length
    typedef struct packed {
        logic                      strobe;
        img_geom_pkg::bank_sel_t   bank;
        img_geom_pkg::word_count_t length;
    } bank_commit_t;

    typedef struct packed {
        img_geom_pkg::word_t data;
        logic                last;
    } readout_beat_t;

    typedef struct packed {
        img_geom_pkg::word_count_t word_count;
        img_geom_pkg::stat_count_t highlights;
        img_geom_pkg::stat_count_t shadows;
    } capture_status_t;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_HEADER,
        WR_WAIT_FRAME_LOW,
        WR_WAIT_FRAME_HIGH,
        WR_PIXELS,
        WR_CHECK_HI,
        WR_CHECK_LO
    } writer_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_STREAM
    } reader_state_e;

endpackage

// ==== logic/img_geom_pkg.sv ====
package img_geom_pkg;

    // ========================================================================
    // Record layout
    // ========================================================================

    localparam int WORD_BITS      = 16;
    localparam int PIXEL_BITS     = 12;
    localparam int HEADER_WORDS   = 4;
    localparam int HEADER_BITS    = HEADER_WORDS * WORD_BITS;
    localparam int CHECKSUM_WORDS = 2;

    // ========================================================================
    // Bank storage
    // ========================================================================

    localparam int BANK_DEPTH     = 256;
    localparam int BANK_COUNT     = 2;
    // Pixels left once header and checksum have their slots
    localparam int PIXEL_CAPACITY = BANK_DEPTH - HEADER_WORDS - CHECKSUM_WORDS;

    // Highlight/shadow sampling
    localparam int STAT_TAG_BITS    = 7;
    localparam int STAT_STRIDE_BITS = 2;
    localparam int STAT_COUNT_BITS  = 18;

    typedef logic [WORD_BITS-1:0]              word_t;
    typedef logic [PIXEL_BITS-1:0]             pixel_t;
    typedef logic [$clog2(BANK_DEPTH)-1:0]     bank_addr_t;
    // One extra bit so a full bank length fits
    typedef logic [$clog2(BANK_DEPTH+1)-1:0]   word_count_t;
    typedef logic [$clog2(BANK_COUNT)-1:0]     bank_sel_t;
    typedef logic [STAT_COUNT_BITS-1:0]        stat_count_t;
    // Word 0 sits in the top bits
    typedef logic [HEADER_BITS-1:0]            header_t;

endpackage
